// ==== source/asg_macros.svh ====
/*
  shared widths, table depth and register map of one generator channel
  included by the packages, the RTL and the testbench
*/

`ifndef ASG_MACROS_SVH
`define ASG_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// fixed point pointer and sample widths
//////////////////////////////////////////////////////////////////////

// table address width, pointer integer part
`define ASG_CWM 8
// pointer fraction width
`define ASG_CWF 8
// sample width
`define ASG_DW 8
// table depth in samples
`define ASG_TDEPTH (1 << `ASG_CWM)

//////////////////////////////////////////////////////////////////////
// register addresses
//////////////////////////////////////////////////////////////////////

`define ASG_REG_CTL  2'd0
`define ASG_REG_MODE 2'd1
`define ASG_REG_BPL  2'd2

`endif

// ==== source/asg_cfg_pkg.sv ====
/*
  configuration register types, MODE decoded as periodic or burst view
*/

`include "asg_macros.svh"

package asg_cfg_pkg;

  // 8.8 fixed point table pointer
  typedef logic [`ASG_CWM+`ASG_CWF-1:0] ptr_t;

  // CTL register, siz in the low half
  typedef struct packed {
    logic [13:0] rsv;
    logic        inf;  // endless burst
    logic        ben;  // burst enable
    ptr_t        siz;  // table size minus one
  } ctl_reg_t;

  // MODE register, view picked by ben
  typedef union packed {
    struct packed {
      ptr_t ste;  // step minus one lsb
      ptr_t off;  // start offset
    } per;
    struct packed {
      logic [15:0] bpn;  // period number minus one
      logic [7:0]  bdl;  // data length minus one
      logic [7:0]  bdr;  // data repetitions minus one
    } bst;
  } mode_word_u;

  // burst period length minus one
  typedef logic [15:0] bpl_t;

endpackage

// ==== source/asg_stream_pkg.sv ====
/*
  read path types shared by the address engines, the table RAM and the stream
*/

`include "asg_macros.svh"

package asg_stream_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample data
  //////////////////////////////////////////////////////////////////////

  // one table entry, also the stream payload
  typedef logic [`ASG_DW-1:0] sample_t;

  //////////////////////////////////////////////////////////////////////
  // table addressing
  //////////////////////////////////////////////////////////////////////

  // table index, integer part of the pointer
  typedef logic [`ASG_CWM-1:0] tbl_addr_t;

endpackage

// ==== source/asg_cfg_if.sv ====
/*
  decoded configuration and qualified control pulses, decode to execute
*/

`timescale 1ns/1ps

interface asg_cfg_if;

  import asg_cfg_pkg::*;

  // generator mode
  logic       ben;
  logic       inf;
  // periodic table size
  ptr_t       siz;
  // burst period length
  bpl_t       bpl;
  // MODE word, both views
  mode_word_u mode;
  // trigger while started
  logic       run;
  // stop request
  logic       stp;

  // register side
  modport decode (
    output ben, inf, siz, bpl, mode, run, stp
  );

  // address engine side
  modport execute (
    input  ben, inf, siz, bpl, mode, run, stp
  );

endinterface

// ==== source/asg_rd_if.sv ====
/*
  table read requests from the address engines and the pipeline advance enable
*/

`timescale 1ns/1ps

interface asg_rd_if;

  import asg_stream_pkg::*;

  // request
  tbl_addr_t addr;
  logic      vld;
  logic      lst;  // last request of a finished burst
  // pipeline may move, from output handshake
  logic      adv;

  modport execute (
    output addr, vld, lst,
    input  adv
  );

  modport result (
    input  addr, vld, lst,
    output adv
  );

endinterface

// ==== source/asg_decode.sv ====
/*
  host register file and start/stop status
  presents CTL, MODE and BPL to the address engines with one qualified trigger
*/

`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_decode (
  input  logic        sto,
  input  logic        ctl_rst,
  input  logic        ctl_str,
  input  logic        ctl_stp,
  input  logic        ctl_trg,
  input  logic        reg_wen,
  input  logic [1:0]  reg_addr,
  input  logic [31:0] reg_wdata,
  output logic        sts_str,
  asg_cfg_if.decode   cfg
);

  import asg_cfg_pkg::*;

  ctl_reg_t   ctl_reg;
  mode_word_u mode_reg;
  bpl_t       bpl_reg;

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  // writes land on the next edge
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ctl_reg  <= '0;
      mode_reg <= '0;
      bpl_reg  <= '0;
    end else if (reg_wen) begin
      case (reg_addr)
        `ASG_REG_CTL:  ctl_reg  <= ctl_reg_t'(reg_wdata);
        `ASG_REG_MODE: mode_reg <= mode_word_u'(reg_wdata);
        // upper half of the word ignored
        `ASG_REG_BPL:  bpl_reg  <= reg_wdata[$bits(bpl_t)-1:0];
        default: ;
      endcase
    end
  end

  // mode bits out of CTL
  assign cfg.ben  = ctl_reg.ben;
  assign cfg.inf  = ctl_reg.inf;
  assign cfg.siz  = ctl_reg.siz;
  assign cfg.bpl  = bpl_reg;
  // both views travel as one word, execute picks by ben
  assign cfg.mode = mode_reg;

  //////////////////////////////////////////////////////////////////////
  // start/stop status
  //////////////////////////////////////////////////////////////////////

  // stop has priority over start
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_str <= 1'b0;
    end else if (ctl_stp) begin
      sts_str <= 1'b0;
    end else if (ctl_str) begin
      sts_str <= 1'b1;
    end
  end

  // trigger counts while started, or with start in the same cycle
  assign cfg.run = ctl_trg & (sts_str | ctl_str);

  // stop passes straight through
  assign cfg.stp = ctl_stp;

endmodule

// ==== source/asg_execute.sv ====
/*
  trigger status and the two address engines
  periodic mode walks an 8.8 pointer, burst mode runs repetition and period counters
*/

`timescale 1ns/1ps

module asg_execute (
  input  logic        sto,
  input  logic        ctl_rst,
  output logic        sts_trg,
  output logic        evn_per,
  output logic [15:0] sts_bpn,
  asg_cfg_if.execute  cfg,
  asg_rd_if.execute   rd
);

  import asg_cfg_pkg::*;
  import asg_stream_pkg::*;

  localparam int PW = $bits(ptr_t);

  // periodic pointer
  ptr_t        ptr_cur;
  logic [PW:0] ptr_nxt;
  logic [PW:0] ptr_sub;
  // burst counters
  logic [7:0]  bdr_cnt;
  tbl_addr_t   bdl_cnt;
  bpl_t        bpl_cnt;
  logic        idl;  // idle part of the period
  // request accepted this cycle
  logic        acc;
  logic        end_bdr;
  logic        end_bdl;
  logic        end_bpl;
  logic        end_bpn;
  logic        fin;
  logic        ctl_end;

  assign acc = sts_trg & rd.adv;

  //////////////////////////////////////////////////////////////////////
  // trigger status
  //////////////////////////////////////////////////////////////////////

  // final period only ends once its last request is taken
  assign ctl_end = cfg.stp | (fin & acc);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_trg <= 1'b0;
    end else if (ctl_end) begin
      sts_trg <= 1'b0;
    end else if (cfg.run) begin
      sts_trg <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // periodic engine
  //////////////////////////////////////////////////////////////////////

  // one extra bit catches the borrow of the wrap
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg.mode.per.ste} + 1'b1;
  assign ptr_sub = ptr_nxt - ({1'b0, cfg.siz} + 1'b1);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (~cfg.ben) begin
      if (cfg.run) begin
        ptr_cur <= cfg.mode.per.off;
      end else if (acc) begin
        // wrap modulo siz+1
        ptr_cur <= ptr_sub[PW] ? ptr_nxt[PW-1:0] : ptr_sub[PW-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // burst engine
  //////////////////////////////////////////////////////////////////////

  assign end_bdr = (bdr_cnt == cfg.mode.bst.bdr);
  assign end_bdl = (bdl_cnt == cfg.mode.bst.bdl);
  assign end_bpl = (bpl_cnt == cfg.bpl);
  assign end_bpn = (sts_bpn == cfg.mode.bst.bpn) & ~cfg.inf;
  // current request closes the final period
  assign fin     = cfg.ben & end_bpl & end_bpn;

  always_ff @(posedge sto) begin
    if (ctl_rst || cfg.run) begin
      bdr_cnt <= '0;
      bdl_cnt <= '0;
      bpl_cnt <= '0;
      sts_bpn <= '0;
      idl     <= 1'b0;
    end else if (cfg.ben && acc) begin
      if (end_bpl) begin
        // new period, data part restarts
        bdr_cnt <= '0;
        bdl_cnt <= '0;
        bpl_cnt <= '0;
        idl     <= 1'b0;
        // count stays on the final period
        sts_bpn <= sts_bpn + {15'd0, ~end_bpn};
      end else begin
        bpl_cnt <= bpl_cnt + 1'b1;
        if (!idl) begin
          if (end_bdr) begin
            bdr_cnt <= '0;
            // last sample done, address held from here on
            if (end_bdl) begin
              idl <= 1'b1;
            end else begin
              bdl_cnt <= bdl_cnt + 1'b1;
            end
          end else begin
            bdr_cnt <= bdr_cnt + 1'b1;
          end
        end
      end
    end
  end

  // period end event
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      evn_per <= 1'b0;
    end else begin
      evn_per <= cfg.ben & acc & end_bpl;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read request
  //////////////////////////////////////////////////////////////////////

  assign rd.addr = cfg.ben ? bdl_cnt : ptr_cur[PW-1 -: $bits(tbl_addr_t)];
  assign rd.vld  = sts_trg;
  assign rd.lst  = sts_trg & fin;

endmodule

// ==== source/asg_result.sv ====
/*
  sample table with host write port, registered read and the output stream register
  requests reach the output two advancing cycles after acceptance
*/

`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_result (
  input  logic                      sto,
  input  logic                      ctl_rst,
  input  logic                      tbl_wen,
  input  asg_stream_pkg::tbl_addr_t tbl_addr,
  input  asg_stream_pkg::sample_t   tbl_wdata,
  input  logic                      out_ready,
  output asg_stream_pkg::sample_t   out_data,
  output logic                      out_valid,
  output logic                      out_last,
  output logic                      evn_lst,
  asg_rd_if.result                  rd
);

  import asg_stream_pkg::*;

  sample_t tbl_mem [0:`ASG_TDEPTH-1];
  // read stage
  sample_t rd_data;
  logic    rd_vld;
  logic    rd_lst;

  // whole pipeline stalls on a refused beat
  assign rd.adv = out_ready | ~out_valid;

  // host write port
  always_ff @(posedge sto) begin
    if (tbl_wen) begin
      tbl_mem[tbl_addr] <= tbl_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (rd.adv) begin
      rd_data <= tbl_mem[rd.addr];
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      rd_vld <= 1'b0;
      rd_lst <= 1'b0;
    end else if (rd.adv) begin
      rd_vld <= rd.vld;
      rd_lst <= rd.lst;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stream register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (rd.adv) begin
      out_data <= rd_data;
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (rd.adv) begin
      out_valid <= rd_vld;
      out_last  <= rd_lst;
    end
  end

  // final beat taken
  assign evn_lst = out_valid & out_ready & out_last;

endmodule

// ==== source/asg_top.sv ====
/*
  one generator channel, registers and control, address engines, table and stream
*/

`timescale 1ns/1ps

module asg_top (
  input  logic                      sto,
  input  logic                      ctl_rst,
  // control pulses
  input  logic                      ctl_str,
  input  logic                      ctl_stp,
  input  logic                      ctl_trg,
  // register write port
  input  logic                      reg_wen,
  input  logic [1:0]                reg_addr,
  input  logic [31:0]               reg_wdata,
  // table write port
  input  logic                      tbl_wen,
  input  asg_stream_pkg::tbl_addr_t tbl_addr,
  input  asg_stream_pkg::sample_t   tbl_wdata,
  // status and events
  output logic                      sts_str,
  output logic                      sts_trg,
  output logic                      evn_per,
  output logic                      evn_lst,
  output logic [15:0]               sts_bpn,
  // sample stream
  output asg_stream_pkg::sample_t   out_data,
  output logic                      out_valid,
  output logic                      out_last,
  input  logic                      out_ready
);

  asg_cfg_if cfg_i ();
  asg_rd_if  rd_i ();

  //////////////////////////////////////////////////////////////////////
  // registers and control
  //////////////////////////////////////////////////////////////////////

  asg_decode decode_i (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .ctl_str   (ctl_str),
    .ctl_stp   (ctl_stp),
    .ctl_trg   (ctl_trg),
    .reg_wen   (reg_wen),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .sts_str   (sts_str),
    .cfg       (cfg_i.decode)
  );

  // address engines
  asg_execute execute_i (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .sts_trg (sts_trg),
    .evn_per (evn_per),
    .sts_bpn (sts_bpn),
    .cfg     (cfg_i.execute),
    .rd      (rd_i.execute)
  );

  // table and stream
  asg_result result_i (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .tbl_wen   (tbl_wen),
    .tbl_addr  (tbl_addr),
    .tbl_wdata (tbl_wdata),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .evn_lst   (evn_lst),
    .rd        (rd_i.result)
  );

endmodule

// ==== verification/asg_tb.sv ====
/*
  testbench for one generator channel, drives registers, table and control pulses
  and checks every accepted beat against a reference model of the periodic and burst rules
*/

`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_tb;

  import asg_cfg_pkg::*;
  import asg_stream_pkg::*;

  // dut inputs
  logic        sto = 1'b0;
  logic        ctl_rst;
  logic        ctl_str;
  logic        ctl_stp;
  logic        ctl_trg;
  logic        reg_wen;
  logic [1:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic        tbl_wen;
  tbl_addr_t   tbl_addr;
  sample_t     tbl_wdata;
  logic        out_ready;
  // dut outputs
  logic        sts_str;
  logic        sts_trg;
  logic        evn_per;
  logic        evn_lst;
  logic [15:0] sts_bpn;
  sample_t     out_data;
  logic        out_valid;
  logic        out_last;

  // model copy of the configuration
  logic        ref_ben;
  logic        ref_inf;
  ptr_t        ref_siz;
  ptr_t        ref_ste;
  ptr_t        ref_off;
  logic [7:0]  ref_bdr;
  logic [7:0]  ref_bdl;
  bpl_t        ref_bpl;
  logic [15:0] ref_bpn;

  // running totals, owned by the checker
  int          beat_cnt = 0;
  int          per_cnt = 0;
  int          lst_cnt = 0;
  int          stall_cnt = 0;
  logic        hold_pend = 1'b0;
  sample_t     hold_data;
  // snapshots taken by the main sequence
  int          beat_base;
  int          per_base;
  int          lst_base;
  int          stall_base;
  // random ready
  logic        bp_en;
  logic [31:0] lfsr;

  asg_top dut_i (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .ctl_str   (ctl_str),
    .ctl_stp   (ctl_stp),
    .ctl_trg   (ctl_trg),
    .reg_wen   (reg_wen),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .tbl_wen   (tbl_wen),
    .tbl_addr  (tbl_addr),
    .tbl_wdata (tbl_wdata),
    .sts_str   (sts_str),
    .sts_trg   (sts_trg),
    .evn_per   (evn_per),
    .evn_lst   (evn_lst),
    .sts_bpn   (sts_bpn),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  // 8 ns period
  always #4 sto = ~sto;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // nibble swap plus xor, so a wrong address shows up
  function automatic sample_t tbl_value(input int a);
    sample_t s;
    s = sample_t'(a);
    return {s[3:0], s[7:4]} ^ 8'h5a;
  endfunction

  // expected n-th beat of the current configuration
  function automatic sample_t ref_sample(input int n);
    logic [16:0] ptr;
    logic [16:0] inc;
    logic [16:0] lim;
    int          k;
    int          pos;
    int          idx;
    ptr = {1'b0, ref_off};
    // engine adds one lsb to step and size
    inc = {1'b0, ref_ste} + 17'd1;
    lim = {1'b0, ref_siz} + 17'd1;
    idx = 0;
    if (!ref_ben) begin
      for (k = 0; k < n; k++) begin
        ptr = ptr + inc;
        if (ptr >= lim) begin
          ptr = ptr - lim;
        end
      end
      // integer part of 8.8
      idx = int'(ptr[15:8]);
    end else begin
      pos = n % (int'(ref_bpl) + 1);
      idx = pos / (int'(ref_bdr) + 1);
      // idle part holds the last data sample
      if (idx > int'(ref_bdl)) begin
        idx = int'(ref_bdl);
      end
    end
    return tbl_value(idx);
  endfunction

  // only the final beat of a finite burst
  function automatic logic ref_last(input int n);
    int total;
    total = (int'(ref_bpn) + 1) * (int'(ref_bpl) + 1);
    return ref_ben && !ref_inf && (n == total - 1);
  endfunction

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checker and ready source
  //////////////////////////////////////////////////////////////////////

  // handshake seen at the rising edge, values from before the edge
  always @(posedge sto) begin
    if (!ctl_rst) begin
      // refused beat must not move
      if (hold_pend) begin
        check_value("held out_valid", 32'd1, 32'(out_valid));
        check_value("held out_data", 32'(hold_data), 32'(out_data));
      end
      if (out_valid && out_ready) begin
        check_value("beat data", 32'(ref_sample(beat_cnt - beat_base)), 32'(out_data));
        check_value("beat last", 32'(ref_last(beat_cnt - beat_base)), 32'(out_last));
        // event only on the final beat of a finite burst
        check_value("beat evn_lst", 32'(ref_last(beat_cnt - beat_base)), 32'(evn_lst));
        beat_cnt = beat_cnt + 1;
      end else begin
        check_value("idle evn_lst", 32'd0, 32'(evn_lst));
      end
      if (evn_per) begin
        per_cnt = per_cnt + 1;
      end
      if (evn_lst) begin
        lst_cnt = lst_cnt + 1;
      end
      if (out_valid && !out_ready) begin
        stall_cnt = stall_cnt + 1;
      end
    end
    hold_pend = !ctl_rst && out_valid && !out_ready;
    hold_data = out_data;
  end

  // one lfsr step per ready bit
  initial begin
    out_ready = 1'b1;
    lfsr = 32'ha4bf25f3;
    forever begin
      @(negedge sto);
      if (bp_en) begin
        lfsr = lfsr_next(lfsr);
        out_ready = lfsr[0];
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    @(negedge sto);
    reg_wen   = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge sto);
    reg_wen   = 1'b0;
  endtask

  task automatic load_table();
    int a;
    for (a = 0; a < `ASG_TDEPTH; a++) begin
      @(negedge sto);
      tbl_wen   = 1'b1;
      tbl_addr  = tbl_addr_t'(a);
      tbl_wdata = tbl_value(a);
    end
    @(negedge sto);
    tbl_wen = 1'b0;
  endtask

  // one-cycle control pulse
  task automatic pulse_ctl(input logic str, input logic stp, input logic trg);
    @(negedge sto);
    ctl_str = str;
    ctl_stp = stp;
    ctl_trg = trg;
    @(negedge sto);
    ctl_str = 1'b0;
    ctl_stp = 1'b0;
    ctl_trg = 1'b0;
  endtask

  task automatic start_trigger();
    pulse_ctl(1'b1, 1'b0, 1'b0);
    check_value("start sts_str", 32'd1, 32'(sts_str));
    pulse_ctl(1'b0, 1'b0, 1'b1);
    check_value("trigger sts_trg", 32'd1, 32'(sts_trg));
  endtask

  task automatic wait_beats(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (beat_cnt - beat_base < n) begin
      if (cyc == limit) begin
        stop_with_failure($sformatf("no %0d beats within %0d cycles", n, limit));
      end
      @(negedge sto);
      cyc++;
    end
  endtask

  // stream drained and engine stopped
  task automatic wait_idle(input int limit);
    int cyc;
    cyc = 0;
    while (sts_trg || out_valid) begin
      if (cyc == limit) begin
        stop_with_failure($sformatf("stream still running after %0d cycles", limit));
      end
      @(negedge sto);
      cyc++;
    end
  endtask

  task automatic take_bases();
    beat_base  = beat_cnt;
    per_base   = per_cnt;
    lst_base   = lst_cnt;
    stall_base = stall_cnt;
  endtask

  // siz 200.0, ste 2.5, off 3.0 in 8.8
  task automatic run_periodic(input logic bp);
    ctl_reg_t   ctl;
    mode_word_u mode;
    ctl          = '0;
    ctl.siz      = 16'hc800;
    mode         = '0;
    mode.per.ste = 16'h0280;
    mode.per.off = 16'h0300;
    write_reg(`ASG_REG_CTL, ctl);
    write_reg(`ASG_REG_MODE, mode);
    ref_ben = 1'b0;
    ref_inf = 1'b0;
    ref_siz = ctl.siz;
    ref_ste = mode.per.ste;
    ref_off = mode.per.off;
    take_bases();
    bp_en = bp;
    start_trigger();
    wait_beats(300, 4000);
    pulse_ctl(1'b0, 1'b1, 1'b0);
    wait_idle(1000);
    bp_en = 1'b0;
    check_value("stop sts_trg", 32'd0, 32'(sts_trg));
    check_value("stop sts_str", 32'd0, 32'(sts_str));
    if (bp) begin
      check_value("stalls seen", 32'd1, 32'(stall_cnt > stall_base));
    end
  endtask

  // 3 repeats of 4 samples, 20-beat period, 3 periods
  task automatic config_burst(input logic inf);
    ctl_reg_t   ctl;
    mode_word_u mode;
    ctl          = '0;
    ctl.ben      = 1'b1;
    ctl.inf      = inf;
    mode         = '0;
    mode.bst.bdr = 8'd2;
    mode.bst.bdl = 8'd3;
    mode.bst.bpn = 16'd2;
    write_reg(`ASG_REG_CTL, ctl);
    write_reg(`ASG_REG_MODE, mode);
    write_reg(`ASG_REG_BPL, 32'd19);
    ref_ben = 1'b1;
    ref_inf = inf;
    ref_bdr = mode.bst.bdr;
    ref_bdl = mode.bst.bdl;
    ref_bpn = mode.bst.bpn;
    ref_bpl = 16'd19;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    ctl_rst   = 1'b1;
    ctl_str   = 1'b0;
    ctl_stp   = 1'b0;
    ctl_trg   = 1'b0;
    reg_wen   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    tbl_wen   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    bp_en     = 1'b0;
    ref_ben   = 1'b0;
    ref_inf   = 1'b0;
    take_bases();
    repeat (5) @(negedge sto);
    ctl_rst = 1'b0;

    // reset state, then a trigger with no start
    check_value("reset sts_str", 32'd0, 32'(sts_str));
    check_value("reset sts_bpn", 32'd0, 32'(sts_bpn));
    load_table();
    pulse_ctl(1'b0, 1'b0, 1'b1);
    for (i = 0; i < 20; i++) begin
      check_value("idle out_valid", 32'd0, 32'(out_valid));
      check_value("idle sts_trg", 32'd0, 32'(sts_trg));
      check_value("idle evn_per", 32'd0, 32'(evn_per));
      check_value("idle evn_lst", 32'd0, 32'(evn_lst));
      @(negedge sto);
    end
    check_value("beats without start", 32'd0, 32'(beat_cnt));

    // periodic stream, ready held high
    run_periodic(1'b0);

    // finite burst ends on its own
    config_burst(1'b0);
    take_bases();
    start_trigger();
    wait_idle(500);
    check_value("burst beats", 32'd60, 32'(beat_cnt - beat_base));
    check_value("burst periods", 32'd3, 32'(per_cnt - per_base));
    check_value("burst last beats", 32'd1, 32'(lst_cnt - lst_base));
    check_value("burst sts_bpn", 32'd2, 32'(sts_bpn));
    check_value("burst sts_str", 32'd1, 32'(sts_str));
    pulse_ctl(1'b0, 1'b1, 1'b0);

    // same periodic stream under random ready
    run_periodic(1'b1);

    // endless burst runs past the period count until stopped
    config_burst(1'b1);
    take_bases();
    start_trigger();
    wait_beats(150, 1000);
    check_value("endless sts_bpn past limit", 32'd1, 32'(sts_bpn > 16'd2));
    pulse_ctl(1'b0, 1'b1, 1'b0);
    wait_idle(200);
    check_value("endless last beats", 32'd0, 32'(lst_cnt - lst_base));
    check_value("endless periods", 32'd1, 32'(per_cnt - per_base >= 7));

    repeat (5) @(negedge sto);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/asg_cfg_pkg.sv
source/asg_stream_pkg.sv
source/asg_cfg_if.sv
source/asg_rd_if.sv
source/asg_decode.sv
source/asg_execute.sv
source/asg_result.sv
source/asg_top.sv
verification/asg_tb.sv

// ==== Makefile ====
# Verilator build and run of the generator channel testbench

SIM = obj_dir/asg_sim

all: run

$(SIM): project.f source/*.sv source/*.svh verification/*.sv
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module asg_tb -o asg_sim

# pass only when the pass message shows up in the output
run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f project.f --top-module asg_tb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
